// File: Makefile
# Verilator build and run for the DES APB testbench.

VERILATOR ?= verilator
TOP       ?= des_tb
SEED_ARGS ?= +verilator+seed+1
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, SEED_ARGS, FILELIST, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf obj_dir

// File: hdl/des_apb_regs.sv
`timescale 1ns/1ps
`include "des_defs.svh"

module des_apb_regs (
  input  logic                   pclk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`DES_APB_AW-1:0] paddr,
  input  logic [`DES_APB_DW-1:0] pwdata,
  output logic [`DES_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   full,
  output logic                   push,
  output des_pkg::des_block_t    push_key,
  output des_pkg::des_block_t    push_block,
  input  des_pkg::des_block_t    result,
  input  logic                   result_valid,
  input  logic                   busy,
  output logic                   result_ack
);

  import des_pkg::*;

  des_reg_e               reg_addr;
  logic                   access;
  logic                   wr;
  logic                   rd;
  logic                   mapped;
  logic                   push_req;
  logic [`DES_APB_DW-1:0] key_hi_q;
  logic [`DES_APB_DW-1:0] key_lo_q;
  logic [`DES_APB_DW-1:0] data_hi_q;
  logic [`DES_APB_DW-1:0] data_lo_q;

  assign reg_addr = des_reg_e'(paddr);
  assign access   = psel & penable;
  assign wr       = access & pwrite;
  assign rd       = access & ~pwrite;

  // Zero wait states.
  assign pready = 1'b1;

  assign push_req   = wr && (reg_addr == REG_CTRL) && pwdata[0];
  assign push       = push_req && !full;
  assign push_key   = {key_hi_q, key_lo_q};
  assign push_block = {data_hi_q, data_lo_q};

  // Reading the low result word retires it.
  assign result_ack = rd && (reg_addr == REG_RES_LO) && result_valid;

  assign pslverr = access && (!mapped || (push_req && full));

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_hi_q  <= '0;
      key_lo_q  <= '0;
      data_hi_q <= '0;
      data_lo_q <= '0;
    end
    else if (wr)
    begin
      case (reg_addr)
        REG_KEY_HI:  key_hi_q  <= pwdata;
        REG_KEY_LO:  key_lo_q  <= pwdata;
        REG_DATA_HI: data_hi_q <= pwdata;
        REG_DATA_LO: data_lo_q <= pwdata;
        default:     ;
      endcase
    end
  end

  always_comb
  begin
    mapped = 1'b1;
    prdata = '0;
    case (reg_addr)
      REG_KEY_HI:  prdata = key_hi_q;
      REG_KEY_LO:  prdata = key_lo_q;
      REG_DATA_HI: prdata = data_hi_q;
      REG_DATA_LO: prdata = data_lo_q;
      REG_CTRL:    prdata = '0;
      REG_STATUS:  prdata = {{(`DES_APB_DW-3){1'b0}}, busy, result_valid, full};
      REG_RES_HI:  prdata = result[`DES_BLOCK_W-1:`DES_HALF_W];
      REG_RES_LO:  prdata = result[`DES_HALF_W-1:0];
      default:     mapped = 1'b0;
    endcase
  end

endmodule

// File: hdl/des_defs.svh
`ifndef DES_DEFS_SVH
`define DES_DEFS_SVH

`define DES_BLOCK_W    64
`define DES_HALF_W     32
`define DES_SUBKEY_W   48
`define DES_CD_W       28
`define DES_ROUNDS     16
`define DES_APB_AW     5
`define DES_APB_DW     32
`define DES_FIFO_DEPTH 2

// APB register byte offsets.
`define DES_REG_KEY_HI  5'h00
`define DES_REG_KEY_LO  5'h04
`define DES_REG_DATA_HI 5'h08
`define DES_REG_DATA_LO 5'h0C
`define DES_REG_CTRL    5'h10
`define DES_REG_STATUS  5'h14
`define DES_REG_RES_HI  5'h18
`define DES_REG_RES_LO  5'h1C

`endif

// File: hdl/des_job_fifo.sv
`timescale 1ns/1ps
`include "des_defs.svh"

module des_job_fifo #(
  parameter int DEPTH = `DES_FIFO_DEPTH
) (
  input  logic                pclk,
  input  logic                rst_n,
  input  logic                push,
  input  des_pkg::des_block_t push_key,
  input  des_pkg::des_block_t push_block,
  output logic                full,
  input  logic                pop,
  output des_pkg::des_block_t pop_key,
  output des_pkg::des_block_t pop_block,
  output logic                empty
);

  import des_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  des_job_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;

  assign full      = (count == CW'(DEPTH));
  assign empty     = (count == '0);
  assign pop_key   = mem[rd_ptr].key;
  assign pop_block = mem[rd_ptr].block;

  always_ff @(posedge pclk)
  begin
    if (push)
      mem[wr_ptr] <= '{key: push_key, block: push_block};
  end

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: hdl/des_pkg.sv
`include "des_defs.svh"

package des_pkg;

  typedef logic [`DES_BLOCK_W-1:0]  des_block_t;
  typedef logic [`DES_HALF_W-1:0]   des_half_t;
  typedef logic [`DES_SUBKEY_W-1:0] des_subkey_t;
  typedef logic [`DES_CD_W-1:0]     des_cd_t;

  typedef struct packed {
    des_block_t key;
    des_block_t block;
  } des_job_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ROUND,
    ST_DONE
  } des_state_e;

  typedef enum logic [`DES_APB_AW-1:0] {
    REG_KEY_HI  = `DES_REG_KEY_HI,
    REG_KEY_LO  = `DES_REG_KEY_LO,
    REG_DATA_HI = `DES_REG_DATA_HI,
    REG_DATA_LO = `DES_REG_DATA_LO,
    REG_CTRL    = `DES_REG_CTRL,
    REG_STATUS  = `DES_REG_STATUS,
    REG_RES_HI  = `DES_REG_RES_HI,
    REG_RES_LO  = `DES_REG_RES_LO
  } des_reg_e;

  // Tables use DES numbering: entry 1 names the most significant bit.
  localparam int unsigned IP_TAB [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

  localparam int unsigned IP_INV_TAB [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

  localparam int unsigned E_TAB [48] = '{
    32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

  localparam int unsigned P_TAB [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};

  localparam int unsigned PC1_TAB [56] = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
    10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
    14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};

  localparam int unsigned PC2_TAB [48] = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
    23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

  // One S-box per entry, rows 0 to 3 of sixteen nibbles, first nibble on top.
  localparam logic [255:0] SBOX_TAB [8] = '{
    256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
    256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
    256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
    256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
    256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
    256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
    256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
    256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B};

  // Rounds 1, 2, 9 and 16 rotate by one.
  localparam logic [15:0] SHIFT_ONE = 16'b1000_0001_0000_0011;

  function automatic des_block_t perm_ip(input des_block_t x);
    des_block_t r;
    for (int i = 0; i < 64; i++)
      r[63-i] = x[64-IP_TAB[i]];
    return r;
  endfunction

  function automatic des_block_t perm_ip_inv(input des_block_t x);
    des_block_t r;
    for (int i = 0; i < 64; i++)
      r[63-i] = x[64-IP_INV_TAB[i]];
    return r;
  endfunction

  function automatic des_subkey_t expand_e(input des_half_t x);
    des_subkey_t r;
    for (int i = 0; i < 48; i++)
      r[47-i] = x[32-E_TAB[i]];
    return r;
  endfunction

  function automatic des_half_t perm_p(input des_half_t x);
    des_half_t r;
    for (int i = 0; i < 32; i++)
      r[31-i] = x[32-P_TAB[i]];
    return r;
  endfunction

  // Outer bits pick the row, inner four the column.
  function automatic logic [3:0] sbox_lookup(input logic [5:0] b, input logic [2:0] box);
    int unsigned idx;
    idx = {b[5], b[0]} * 16 + b[4:1];
    return SBOX_TAB[box][255-4*idx -: 4];
  endfunction

  function automatic des_half_t feistel_f(input des_half_t r, input des_subkey_t k);
    des_subkey_t t;
    des_half_t s;
    t = expand_e(r) ^ k;
    for (int i = 0; i < 8; i++)
      s[31-4*i -: 4] = sbox_lookup(t[47-6*i -: 6], 3'(i));
    return perm_p(s);
  endfunction

  // Result is {C, D}.
  function automatic logic [2*`DES_CD_W-1:0] key_pc1(input des_block_t k);
    logic [2*`DES_CD_W-1:0] r;
    for (int i = 0; i < 56; i++)
      r[55-i] = k[64-PC1_TAB[i]];
    return r;
  endfunction

  function automatic des_subkey_t key_pc2(input des_cd_t c, input des_cd_t d);
    logic [2*`DES_CD_W-1:0] cd;
    des_subkey_t r;
    cd = {c, d};
    for (int i = 0; i < 48; i++)
      r[47-i] = cd[56-PC2_TAB[i]];
    return r;
  endfunction

  // Round index counts from zero.
  function automatic logic [1:0] shift_amount(input logic [3:0] round);
    return SHIFT_ONE[round] ? 2'd1 : 2'd2;
  endfunction

endpackage

// File: hdl/des_round_engine.sv
`timescale 1ns/1ps
`include "des_defs.svh"

module des_round_engine (
  input  logic                pclk,
  input  logic                rst_n,
  input  logic                empty,
  output logic                pop,
  input  des_pkg::des_block_t pop_key,
  input  des_pkg::des_block_t pop_block,
  output des_pkg::des_block_t result,
  output logic                result_valid,
  output logic                busy,
  input  logic                result_ack
);

  import des_pkg::*;

  des_state_e  state_q;
  logic [3:0]  round_q;
  logic        last_round;
  des_half_t   l_q;
  des_half_t   r_q;
  des_half_t   r_next;
  des_cd_t     c_q;
  des_cd_t     d_q;
  des_cd_t     c_next;
  des_cd_t     d_next;
  des_subkey_t subkey;

  assign pop        = (state_q == ST_IDLE) && !empty;
  assign last_round = (round_q == 4'(`DES_ROUNDS - 1));

  // Key schedule rotation and one Feistel step.
  always_comb
  begin
    if (shift_amount(round_q) == 2'd1)
    begin
      c_next = {c_q[`DES_CD_W-2:0], c_q[`DES_CD_W-1]};
      d_next = {d_q[`DES_CD_W-2:0], d_q[`DES_CD_W-1]};
    end
    else
    begin
      c_next = {c_q[`DES_CD_W-3:0], c_q[`DES_CD_W-1:`DES_CD_W-2]};
      d_next = {d_q[`DES_CD_W-3:0], d_q[`DES_CD_W-1:`DES_CD_W-2]};
    end
    subkey = key_pc2(c_next, d_next);
    r_next = l_q ^ feistel_f(r_q, subkey);
  end

  always_ff @(posedge pclk)
  begin
    if (pop)
    begin
      {l_q, r_q} <= perm_ip(pop_block);
      {c_q, d_q} <= key_pc1(pop_key);
    end
    else if (state_q == ST_ROUND)
    begin
      l_q <= r_q;
      r_q <= r_next;
      c_q <= c_next;
      d_q <= d_next;
    end
  end

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= ST_IDLE;
      round_q      <= '0;
      result       <= '0;
      result_valid <= 1'b0;
      busy         <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
          if (pop)
          begin
            state_q <= ST_ROUND;
            round_q <= '0;
            busy    <= 1'b1;
          end
        ST_ROUND:
        begin
          round_q <= round_q + 1'b1;
          if (last_round)
          begin
            // Halves swap before the final permutation.
            result       <= perm_ip_inv({r_next, r_q});
            result_valid <= 1'b1;
            state_q      <= ST_DONE;
          end
        end
        ST_DONE:
          if (result_ack)
          begin
            result_valid <= 1'b0;
            busy         <= 1'b0;
            state_q      <= ST_IDLE;
          end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/des_top.sv
`timescale 1ns/1ps
`include "des_defs.svh"

module des_top (
  input  logic                   pclk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`DES_APB_AW-1:0] paddr,
  input  logic [`DES_APB_DW-1:0] pwdata,
  output logic [`DES_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr
);

  import des_pkg::*;

  logic       push;
  logic       full;
  logic       pop;
  logic       empty;
  logic       result_valid;
  logic       busy;
  logic       result_ack;
  des_block_t push_key;
  des_block_t push_block;
  des_block_t pop_key;
  des_block_t pop_block;
  des_block_t result;

  des_apb_regs u_regs (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .full, .push, .push_key, .push_block,
    .result, .result_valid, .busy, .result_ack
  );

  des_job_fifo #(.DEPTH(`DES_FIFO_DEPTH)) u_fifo (
    .pclk, .rst_n, .push, .push_key, .push_block, .full,
    .pop, .pop_key, .pop_block, .empty
  );

  des_round_engine u_engine (
    .pclk, .rst_n, .empty, .pop, .pop_key, .pop_block,
    .result, .result_valid, .busy, .result_ack
  );

endmodule

// File: tb.f
+incdir+hdl
hdl/des_pkg.sv
hdl/des_apb_regs.sv
hdl/des_job_fifo.sv
hdl/des_round_engine.sv
hdl/des_top.sv
tests/des_props.sv
tests/des_tb.sv

// File: tests/des_props.sv
`timescale 1ns/1ps

module des_props (
  input logic                 pclk,
  input logic                 rst_n,
  input des_pkg::des_state_e  state_q,
  input logic [3:0]           round_q,
  input logic                 empty,
  input logic                 pop,
  input logic                 result_valid,
  input logic                 result_ack,
  input logic                 busy
);

  import des_pkg::*;

  // Jobs leave the FIFO only into an idle engine.
  pop_when_idle: assert property (@(posedge pclk) disable iff (!rst_n)
    pop |-> !busy && !result_valid && !empty)
    else $error("pop while the engine holds a job or a result, or from an empty FIFO");

  valid_until_ack: assert property (@(posedge pclk) disable iff (!rst_n)
    result_valid && !result_ack |=> result_valid)
    else $error("result_valid dropped without result_ack");

  // Counter wraps to zero after the last round and rests there.
  round_rests_at_zero: assert property (@(posedge pclk) disable iff (!rst_n)
    (state_q != ST_ROUND) |-> (round_q == '0))
    else $error("round counter nonzero outside ST_ROUND");

  idle_not_busy: assert property (@(posedge pclk) disable iff (!rst_n)
    (state_q == ST_IDLE) |-> !busy)
    else $error("busy high in ST_IDLE");

endmodule

bind des_round_engine des_props u_props (
  .pclk, .rst_n, .state_q, .round_q, .empty, .pop,
  .result_valid, .result_ack, .busy
);

// File: tests/des_tb.sv
`timescale 1ns/1ps
`include "des_defs.svh"

module des_tb;

  import des_pkg::*;

  localparam int RANDOM_JOBS = 200;
  localparam int POLL_LIMIT  = 100;

  logic                   pclk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`DES_APB_AW-1:0] paddr;
  logic [`DES_APB_DW-1:0] pwdata;
  logic [`DES_APB_DW-1:0] prdata;
  logic                   pready;
  logic                   pslverr;

  des_top u_des_top (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial
  begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
  end

  task automatic stop_on_failure(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_block(input string name, input des_block_t exp, input des_block_t act);
    if (act !== exp)
    begin
      $display("error: %s expected %h actual %h", name, exp, act);
      stop_on_failure({"block mismatch in ", name});
    end
  endtask

  task automatic check_word(input string name, input logic [`DES_APB_DW-1:0] exp,
                            input logic [`DES_APB_DW-1:0] act);
    if (act !== exp)
    begin
      $display("error: %s expected %h actual %h", name, exp, act);
      stop_on_failure({"read data mismatch in ", name});
    end
  endtask

  task automatic check_status(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp)
    begin
      $display("error: %s expected %b actual %b", name, exp, act);
      stop_on_failure({"status mismatch in ", name});
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("error: %s expected %b actual %b", name, exp, act);
      stop_on_failure({"pslverr mismatch in ", name});
    end
  endtask

  // Setup phase, then access phase sampled at the falling edge.
  task automatic apb_access(input logic write, input logic [`DES_APB_AW-1:0] addr,
                            input logic [`DES_APB_DW-1:0] wdata,
                            output logic [`DES_APB_DW-1:0] rdata, output logic err);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    // Zero wait states, so the first access cycle completes.
    if (pready !== 1'b1)
      stop_on_failure("pready was low in the first APB access cycle");
    rdata = prdata;
    err   = pslverr;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`DES_APB_AW-1:0] addr,
                           input logic [`DES_APB_DW-1:0] data, output logic err);
    logic [`DES_APB_DW-1:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`DES_APB_AW-1:0] addr,
                          output logic [`DES_APB_DW-1:0] data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // Stage key and block, then request the push.
  task automatic submit_job(input des_block_t key, input des_block_t pt, output logic err);
    logic e;
    apb_write(REG_KEY_HI, key[63:32], e);
    check_err("stage_key_hi", 1'b0, e);
    apb_write(REG_KEY_LO, key[31:0], e);
    check_err("stage_key_lo", 1'b0, e);
    apb_write(REG_DATA_HI, pt[63:32], e);
    check_err("stage_data_hi", 1'b0, e);
    apb_write(REG_DATA_LO, pt[31:0], e);
    check_err("stage_data_lo", 1'b0, e);
    apb_write(REG_CTRL, 32'h1, err);
  endtask

  task automatic wait_result();
    logic [`DES_APB_DW-1:0] word;
    logic                   err;
    int                     polls;
    polls = 0;
    apb_read(REG_STATUS, word, err);
    while (!word[1])
    begin
      if (polls >= POLL_LIMIT)
        stop_on_failure("result valid never rose while polling STATUS");
      polls++;
      apb_read(REG_STATUS, word, err);
    end
  endtask

  task automatic read_result(output des_block_t ct);
    logic [`DES_APB_DW-1:0] hi;
    logic [`DES_APB_DW-1:0] lo;
    logic                   err;
    apb_read(REG_RES_HI, hi, err);
    check_err("read_res_hi", 1'b0, err);
    apb_read(REG_RES_LO, lo, err);
    check_err("read_res_lo", 1'b0, err);
    ct = {hi, lo};
  endtask

  function automatic des_block_t des_encrypt_model(input des_block_t key, input des_block_t pt);
    des_cd_t     c;
    des_cd_t     d;
    des_half_t   l;
    des_half_t   r;
    des_half_t   t;
    des_subkey_t k;
    {c, d} = key_pc1(key);
    {l, r} = perm_ip(pt);
    for (int i = 0; i < `DES_ROUNDS; i++)
    begin
      for (int s = 0; s < int'(shift_amount(4'(i))); s++)
      begin
        c = {c[`DES_CD_W-2:0], c[`DES_CD_W-1]};
        d = {d[`DES_CD_W-2:0], d[`DES_CD_W-1]};
      end
      k = key_pc2(c, d);
      t = r;
      r = l ^ feistel_f(r, k);
      l = t;
    end
    return perm_ip_inv({r, l});
  endfunction

  initial
  begin
    des_block_t             key;
    des_block_t             pt;
    des_block_t             ct;
    des_block_t             job_key [3];
    des_block_t             job_pt [3];
    logic [`DES_APB_DW-1:0] word;
    logic [`DES_APB_DW-1:0] hi;
    logic [`DES_APB_DW-1:0] lo;
    logic                   err;

    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rst_n   = 1'b0;
    void'($urandom(32'hf4a8_9cc2));
    repeat (16) @(posedge pclk);
    rst_n <= 1'b1;

    apb_read(REG_STATUS, word, err);
    check_status("reset_status", 3'b000, word[2:0]);
    check_err("reset_status_err", 1'b0, err);
    apb_read(REG_RES_HI, hi, err);
    apb_read(REG_RES_LO, lo, err);
    check_block("reset_result", '0, {hi, lo});

    // Known answer vector.
    key = 64'h1334_5779_9BBC_DFF1;
    pt  = 64'h0123_4567_89AB_CDEF;
    check_block("model_known_answer", 64'h85E8_1354_0F0A_B405, des_encrypt_model(key, pt));
    submit_job(key, pt, err);
    check_err("kat_push", 1'b0, err);
    wait_result();
    read_result(ct);
    check_block("known_answer", 64'h85E8_1354_0F0A_B405, ct);

    for (int n = 0; n < RANDOM_JOBS; n++)
    begin
      key = {$urandom, $urandom};
      pt  = {$urandom, $urandom};
      submit_job(key, pt, err);
      check_err("random_push", 1'b0, err);
      wait_result();
      read_result(ct);
      check_block($sformatf("random_%0d", n), des_encrypt_model(key, pt), ct);
    end

    // Stall the engine with an unread result, then fill the queue.
    key = {$urandom, $urandom};
    pt  = {$urandom, $urandom};
    submit_job(key, pt, err);
    check_err("stall_push", 1'b0, err);
    wait_result();
    for (int j = 0; j < 3; j++)
    begin
      job_key[j] = {$urandom, $urandom};
      job_pt[j]  = {$urandom, $urandom};
    end
    submit_job(job_key[0], job_pt[0], err);
    check_err("queue_push_0", 1'b0, err);
    submit_job(job_key[1], job_pt[1], err);
    check_err("queue_push_1", 1'b0, err);
    apb_read(REG_STATUS, word, err);
    check_status("queue_full_status", 3'b111, word[2:0]);
    submit_job(job_key[2], job_pt[2], err);
    check_err("queue_push_full", 1'b1, err);
    read_result(ct);
    check_block("queue_stall_result", des_encrypt_model(key, pt), ct);
    wait_result();
    read_result(ct);
    check_block("queue_result_0", des_encrypt_model(job_key[0], job_pt[0]), ct);
    wait_result();
    read_result(ct);
    check_block("queue_result_1", des_encrypt_model(job_key[1], job_pt[1]), ct);
    apb_read(REG_STATUS, word, err);
    check_status("queue_drained_status", 3'b000, word[2:0]);
    submit_job(job_key[2], job_pt[2], err);
    check_err("queue_push_retry", 1'b0, err);
    wait_result();
    read_result(ct);
    check_block("queue_result_2", des_encrypt_model(job_key[2], job_pt[2]), ct);

    apb_read(5'h02, word, err);
    check_word("unmapped_read", '0, word);
    check_err("unmapped_read_err", 1'b1, err);
    apb_write(5'h03, 32'hFFFF_FFFF, err);
    check_err("unmapped_write_err", 1'b1, err);

    // Only the low result word retires the result.
    key = {$urandom, $urandom};
    pt  = {$urandom, $urandom};
    submit_job(key, pt, err);
    check_err("ack_push", 1'b0, err);
    wait_result();
    apb_read(REG_RES_HI, hi, err);
    apb_read(REG_STATUS, word, err);
    check_status("after_res_hi_status", 3'b110, word[2:0]);
    apb_read(REG_RES_LO, lo, err);
    check_block("ack_result", des_encrypt_model(key, pt), {hi, lo});
    apb_read(REG_STATUS, word, err);
    check_status("after_res_lo_status", 3'b000, word[2:0]);

    $display("Test passed");
    $finish;
  end

endmodule
